// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = execute_unit_tb
FILELIST = rv_execute.f
BUILD_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(BUILD_DIR)

// File: alu.sv
`default_nettype none

module alu (
  input  execute_pkg::word_t   rdata1,
  input  execute_pkg::word_t   rdata2,
  input  execute_pkg::word_t   imm,
  input  logic                 sel,
  input  execute_pkg::alu_op_t alu_op,
  output execute_pkg::word_t   result
);

  execute_pkg::word_t operand;
  logic [4:0] shamt;

  // Register form when rs2 is read
  assign operand = sel ? rdata2 : imm;
  assign shamt = operand[4:0];

  always_comb begin
    case (alu_op)
      execute_pkg::ALU_ADD: result = rdata1 + operand;
      execute_pkg::ALU_SUB: result = rdata1 - operand;
      execute_pkg::ALU_SLL: result = rdata1 << shamt;
      execute_pkg::ALU_SLT: result = {31'b0, $signed(rdata1) < $signed(operand)};
      execute_pkg::ALU_SLTU: result = {31'b0, rdata1 < operand};
      execute_pkg::ALU_XOR: result = rdata1 ^ operand;
      execute_pkg::ALU_SRL: result = rdata1 >> shamt;
      execute_pkg::ALU_SRA: result = $signed(rdata1) >>> shamt;
      execute_pkg::ALU_OR: result = rdata1 | operand;
      execute_pkg::ALU_AND: result = rdata1 & operand;
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: divider.sv
`default_nettype none

module divider (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 enable,
  input  execute_pkg::div_op_t op,
  input  execute_pkg::word_t   rdata1,
  input  execute_pkg::word_t   rdata2,
  output logic                 ready,
  output execute_pkg::word_t   result
);

  typedef enum logic [1:0] {IDLE, RUN, DONE} state_t;

  state_t state;
  logic [4:0] count;
  logic rem_sel;
  logic neg_quo;
  logic neg_rem;
  logic op_signed;
  execute_pkg::word_t divisor;
  execute_pkg::word_t quo;
  execute_pkg::word_t rem;
  execute_pkg::word_t mag1;
  execute_pkg::word_t mag2;
  logic [32:0] rem_shift;
  logic [32:0] diff;

  assign op_signed = (op == execute_pkg::DIV_DIV) || (op == execute_pkg::DIV_REM);
  assign mag1 = (op_signed && rdata1[31]) ? -rdata1 : rdata1;
  assign mag2 = (op_signed && rdata2[31]) ? -rdata2 : rdata2;

  // Restoring step, quotient bits enter from the right
  assign rem_shift = {rem, quo[31]};
  assign diff = rem_shift - {1'b0, divisor};

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (enable) begin
            state <= (rdata2 == '0) ? DONE : RUN;
          end
        end
        RUN: begin
          if (count == 5'd31) begin
            state <= DONE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == IDLE && enable) begin
      rem_sel <= (op == execute_pkg::DIV_REM) || (op == execute_pkg::DIV_REMU);
      divisor <= mag2;
      count <= '0;
      if (rdata2 == '0) begin
        quo <= '1;
        rem <= rdata1;
        neg_quo <= 1'b0;
        neg_rem <= 1'b0;
      end else begin
        quo <= mag1;
        rem <= '0;
        neg_quo <= op_signed & (rdata1[31] ^ rdata2[31]);
        neg_rem <= op_signed & rdata1[31];
      end
    end else if (state == RUN) begin
      count <= count + 5'd1;
      if (diff[32] == 1'b0) begin
        rem <= diff[31:0];
        quo <= {quo[30:0], 1'b1};
      end else begin
        rem <= rem_shift[31:0];
        quo <= {quo[30:0], 1'b0};
      end
    end
  end

  // Overflow needs no special case, the magnitude of the minimum wraps back to itself
  assign ready = state == DONE;
  assign result = rem_sel ? (neg_rem ? -rem : rem) : (neg_quo ? -quo : quo);

  assert property (@(posedge clock) disable iff (reset == 0) enable |-> state == IDLE);

endmodule

`default_nettype wire

// File: execute_pkg.sv
`default_nettype none

package execute_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [3:0] alu_op_t;
  typedef logic [1:0] mul_op_t;
  typedef logic [1:0] div_op_t;
  typedef logic [2:0] lsu_op_t;
  typedef logic [3:0] byte_enable_t;
  typedef logic [3:0] ecause_t;

  localparam alu_op_t ALU_ADD = 4'd0;
  localparam alu_op_t ALU_SUB = 4'd1;
  localparam alu_op_t ALU_SLL = 4'd2;
  localparam alu_op_t ALU_SLT = 4'd3;
  localparam alu_op_t ALU_SLTU = 4'd4;
  localparam alu_op_t ALU_XOR = 4'd5;
  localparam alu_op_t ALU_SRL = 4'd6;
  localparam alu_op_t ALU_SRA = 4'd7;
  localparam alu_op_t ALU_OR = 4'd8;
  localparam alu_op_t ALU_AND = 4'd9;

  // Low bits of funct3
  localparam mul_op_t MUL_MUL = 2'd0;
  localparam mul_op_t MUL_MULH = 2'd1;
  localparam mul_op_t MUL_MULHSU = 2'd2;
  localparam mul_op_t MUL_MULHU = 2'd3;

  localparam div_op_t DIV_DIV = 2'd0;
  localparam div_op_t DIV_DIVU = 2'd1;
  localparam div_op_t DIV_REM = 2'd2;
  localparam div_op_t DIV_REMU = 2'd3;

  // Load funct3 encoding
  localparam lsu_op_t LSU_LB = 3'd0;
  localparam lsu_op_t LSU_LH = 3'd1;
  localparam lsu_op_t LSU_LW = 3'd2;
  localparam lsu_op_t LSU_LBU = 3'd4;
  localparam lsu_op_t LSU_LHU = 3'd5;

  // Machine mode mcause values
  localparam ecause_t EXC_ILLEGAL_INSTRUCTION = 4'd2;
  localparam ecause_t EXC_BREAKPOINT = 4'd3;
  localparam ecause_t EXC_LOAD_ACCESS_FAULT = 4'd5;
  localparam ecause_t EXC_STORE_ACCESS_FAULT = 4'd7;
  localparam ecause_t EXC_ECALL_M = 4'd11;

endpackage

`default_nettype wire

// File: execute_stage.sv
`default_nettype none

module execute_stage (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      issue,
  input  logic                      clear,
  input  execute_pkg::word_t        pc, instr, address,
  input  execute_pkg::word_t        rdata1, rdata2, imm, sdata,
  input  execute_pkg::reg_addr_t    waddr,
  input  logic                      wren, rden2, lui, auipc, jal, jalr,
  input  logic                      load, store, mult, division,
  input  logic                      ecall, ebreak, illegal,
  input  execute_pkg::alu_op_t      alu_op,
  input  execute_pkg::mul_op_t      mul_op,
  input  execute_pkg::div_op_t      div_op,
  input  execute_pkg::lsu_op_t      lsu_op,
  input  execute_pkg::byte_enable_t byte_enable,
  input  logic                      mem_ready,
  input  logic                      mem_error,
  input  execute_pkg::word_t        mem_rdata,
  input  execute_pkg::word_t        alu_result,
  input  logic                      mul_ready,
  input  execute_pkg::word_t        mul_result,
  input  logic                      div_ready,
  input  execute_pkg::word_t        div_result,
  input  execute_pkg::word_t        load_data,
  output execute_pkg::word_t        operand_a, operand_b, alu_imm,
  output logic                      alu_sel,
  output execute_pkg::alu_op_t      alu_func,
  output logic                      mul_enable,
  output execute_pkg::mul_op_t      mul_func,
  output logic                      div_enable,
  output execute_pkg::div_op_t      div_func,
  output execute_pkg::word_t        load_rdata,
  output execute_pkg::byte_enable_t load_byte_enable,
  output execute_pkg::lsu_op_t      load_func,
  output logic                      stall,
  output logic                      write_enable,
  output execute_pkg::reg_addr_t    write_addr,
  output execute_pkg::word_t        write_data,
  output logic                      exception,
  output execute_pkg::ecause_t      ecause,
  output execute_pkg::word_t        epc,
  output execute_pkg::word_t        etval,
  output logic                      retired
);

  logic active;
  logic trap_decode;
  logic mem_access;
  logic mul_live;
  logic div_live;
  logic launched;
  logic div_stale;
  logic [3:0] mul_stale;
  logic mul_drop;
  logic mul_done;
  logic div_done;
  logic cancel_mul;
  logic cancel_div;
  logic done;
  logic fault;
  logic take_exc;
  execute_pkg::word_t npc;
  execute_pkg::word_t wdata;
  execute_pkg::ecause_t cause;
  execute_pkg::word_t tval;

  assign active = issue & ~clear;
  assign trap_decode = illegal | ebreak | ecall;
  assign mem_access = (load | store) & ~trap_decode;
  assign mul_live = mult & ~trap_decode;
  assign div_live = division & ~trap_decode;

  assign operand_a = rdata1;
  assign operand_b = rdata2;
  assign alu_imm = imm;
  assign alu_sel = rden2;
  assign alu_func = alu_op;
  assign mul_func = mul_op;
  assign div_func = div_op;
  assign load_rdata = mem_rdata;
  assign load_byte_enable = byte_enable;
  assign load_func = lsu_op;

  // Readies still owed to cancelled operations are dropped
  assign mul_drop = mul_ready & (mul_stale != '0);
  assign mul_done = mul_ready & ~mul_drop;
  assign div_done = div_ready & ~div_stale;

  assign mul_enable = active & mul_live & ~launched;
  assign div_enable = active & div_live & ~launched & ~div_stale;

  assign cancel_mul = clear & launched & mul_live & ~mul_done;
  assign cancel_div = clear & launched & div_live & ~div_done;

  assign done = mul_live ? mul_done :
                div_live ? div_done :
                mem_access ? mem_ready : 1'b1;

  assign stall = active & ~done;
  assign fault = mem_access & mem_ready & mem_error;
  assign take_exc = trap_decode | fault;

  // Compressed encodings step by 2
  assign npc = pc + ((instr[1:0] == 2'b11) ? 32'd4 : 32'd2);

  always_comb begin
    wdata = alu_result;
    if (auipc) begin
      wdata = address;
    end else if (lui) begin
      wdata = imm;
    end else if (jal | jalr) begin
      wdata = npc;
    end
    if (mul_live) begin
      wdata = mul_result;
    end else if (div_live) begin
      wdata = div_result;
    end else if (load) begin
      wdata = load_data;
    end
  end

  always_comb begin
    tval = instr;
    if (illegal) begin
      cause = execute_pkg::EXC_ILLEGAL_INSTRUCTION;
    end else if (ebreak) begin
      cause = execute_pkg::EXC_BREAKPOINT;
    end else if (ecall) begin
      cause = execute_pkg::EXC_ECALL_M;
    end else begin
      cause = load ? execute_pkg::EXC_LOAD_ACCESS_FAULT : execute_pkg::EXC_STORE_ACCESS_FAULT;
      tval = address;
    end
  end

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      launched <= 1'b0;
      div_stale <= 1'b0;
      mul_stale <= '0;
    end else begin
      if (clear | mul_done | div_done) begin
        launched <= 1'b0;
      end else if (mul_enable | div_enable) begin
        launched <= 1'b1;
      end
      if (cancel_div) begin
        div_stale <= 1'b1;
      end else if (div_ready) begin
        div_stale <= 1'b0;
      end
      // Enough for up to 15 multiplier stages
      mul_stale <= mul_stale + {3'b0, cancel_mul} - {3'b0, mul_drop};
    end
  end

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      write_enable <= 1'b0;
      exception <= 1'b0;
      retired <= 1'b0;
    end else begin
      write_enable <= active & done & ~take_exc & (mem_access ? load : wren) & (waddr != '0);
      exception <= active & done & take_exc;
      retired <= active & done & ~take_exc;
    end
  end

  always_ff @(posedge clock) begin
    write_addr <= waddr;
    write_data <= wdata;
    ecause <= cause;
    epc <= pc;
    etval <= tval;
  end

  assert property (@(posedge clock) disable iff (reset == 0)
    stall |=> !write_enable && !exception);

  assert property (@(posedge clock) disable iff (reset == 0)
    mul_enable |=> launched && !mul_enable);

  // Source holds the instruction while stalled
  assert property (@(posedge clock) disable iff (reset == 0)
    stall |=> $stable({pc, instr, address, sdata, waddr}));

endmodule

`default_nettype wire

// File: execute_unit.sv
`default_nettype none

module execute_unit #(
  parameter int MUL_STAGES = 2
) (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      issue,
  input  logic                      clear,
  input  execute_pkg::word_t        pc, instr, address,
  input  execute_pkg::word_t        rdata1, rdata2, imm, sdata,
  input  execute_pkg::reg_addr_t    waddr,
  input  logic                      wren, rden2, lui, auipc, jal, jalr,
  input  logic                      load, store, mult, division,
  input  logic                      ecall, ebreak, illegal,
  input  execute_pkg::alu_op_t      alu_op,
  input  execute_pkg::mul_op_t      mul_op,
  input  execute_pkg::div_op_t      div_op,
  input  execute_pkg::lsu_op_t      lsu_op,
  input  execute_pkg::byte_enable_t byte_enable,
  input  logic                      mem_ready,
  input  logic                      mem_error,
  input  execute_pkg::word_t        mem_rdata,
  output logic                      stall,
  output logic                      write_enable,
  output execute_pkg::reg_addr_t    write_addr,
  output execute_pkg::word_t        write_data,
  output logic                      exception,
  output execute_pkg::ecause_t      ecause,
  output execute_pkg::word_t        epc,
  output execute_pkg::word_t        etval,
  output logic                      retired
);

  execute_pkg::word_t alu_result, mul_result, div_result, load_data;
  execute_pkg::word_t operand_a, operand_b, alu_imm, load_rdata;
  logic mul_ready, div_ready, alu_sel, mul_enable, div_enable;
  execute_pkg::alu_op_t alu_func;
  execute_pkg::mul_op_t mul_func;
  execute_pkg::div_op_t div_func;
  execute_pkg::lsu_op_t load_func;
  execute_pkg::byte_enable_t load_byte_enable;

  execute_stage stage_i (.*);

  alu alu_i (
    .rdata1 (operand_a),
    .rdata2 (operand_b),
    .imm    (alu_imm),
    .sel    (alu_sel),
    .alu_op (alu_func),
    .result (alu_result)
  );

  multiplier #(
    .MUL_STAGES (MUL_STAGES)
  ) multiplier_i (
    .clock  (clock),
    .reset  (reset),
    .enable (mul_enable),
    .op     (mul_func),
    .rdata1 (operand_a),
    .rdata2 (operand_b),
    .ready  (mul_ready),
    .result (mul_result)
  );

  divider divider_i (
    .clock  (clock),
    .reset  (reset),
    .enable (div_enable),
    .op     (div_func),
    .rdata1 (operand_a),
    .rdata2 (operand_b),
    .ready  (div_ready),
    .result (div_result)
  );

  load_align load_align_i (
    .rdata       (load_rdata),
    .byte_enable (load_byte_enable),
    .lsu_op      (load_func),
    .data        (load_data)
  );

endmodule

`default_nettype wire

// File: execute_unit_tb.sv
`default_nettype none

module execute_unit_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CYCLE_LIMIT = 200 * 40;

  typedef struct {
    logic valid;
    logic exc;
    logic [4:0] addr;
    logic [31:0] data;
    logic [3:0] cause;
    logic [31:0] epc;
    logic [31:0] tval;
    int cycle;
  } expect_t;

  logic clock, reset, issue, clear;
  execute_pkg::word_t pc, instr, address, rdata1, rdata2, imm, sdata;
  execute_pkg::reg_addr_t waddr;
  logic wren, rden2, lui, auipc, jal, jalr, load, store, mult, division;
  logic ecall, ebreak, illegal;
  execute_pkg::alu_op_t alu_op;
  execute_pkg::mul_op_t mul_op;
  execute_pkg::div_op_t div_op;
  execute_pkg::lsu_op_t lsu_op;
  execute_pkg::byte_enable_t byte_enable;
  logic mem_ready, mem_error;
  execute_pkg::word_t mem_rdata;
  logic stall, write_enable, exception, retired;
  execute_pkg::reg_addr_t write_addr;
  execute_pkg::word_t write_data, epc, etval;
  execute_pkg::ecause_t ecause;

  logic [31:0] seed = 32'd18588;
  int cycle = 0;
  int error_count = 0;
  int check_count = 0;
  expect_t expected[$];

  execute_unit #(.MUL_STAGES(2)) execute_unit_i (.*);

  initial begin
    clock = 1'b0;
    forever begin
      #50 clock = ~clock;
    end
  end

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [31:0] random_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi[31:16], lo[31:16]};
  endfunction

  function automatic int random_below(int n);
    logic [31:0] r;
    r = lcg_next();
    return int'(r[30:16]) % n;
  endfunction

  // Corner values show up often
  function automatic logic [31:0] operand_value();
    case (random_below(6))
      0: return 32'h8000_0000;
      1: return 32'hffff_ffff;
      2: return 32'h7fff_ffff;
      3: return 32'h0;
      default: return random_word();
    endcase
  endfunction

  function automatic logic [31:0] alu_model(logic [3:0] op, logic [31:0] a, logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      execute_pkg::ALU_ADD: return a + b;
      execute_pkg::ALU_SUB: return a + ~b + 32'd1;
      execute_pkg::ALU_SLL: return a << sh;
      execute_pkg::ALU_SLT: return {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
      execute_pkg::ALU_SLTU: return {31'b0, a < b};
      execute_pkg::ALU_XOR: return a ^ b;
      execute_pkg::ALU_SRL: return a >> sh;
      // Logical shift with the sign filled in
      execute_pkg::ALU_SRA: return (a >> sh) | ({32{a[31]}} & ~(32'hffff_ffff >> sh));
      execute_pkg::ALU_OR: return a | b;
      execute_pkg::ALU_AND: return a & b;
      default: return 32'h0;
    endcase
  endfunction

  function automatic logic [31:0] mul_model(logic [1:0] op, logic [31:0] a, logic [31:0] b);
    logic [63:0] wide_a;
    logic [63:0] wide_b;
    logic [63:0] prod;
    wide_a = (op == execute_pkg::MUL_MULH || op == execute_pkg::MUL_MULHSU) ?
             {{32{a[31]}}, a} : {32'b0, a};
    wide_b = (op == execute_pkg::MUL_MULH) ? {{32{b[31]}}, b} : {32'b0, b};
    prod = wide_a * wide_b;
    return (op == execute_pkg::MUL_MUL) ? prod[31:0] : prod[63:32];
  endfunction

  function automatic logic [31:0] div_model(logic [1:0] op, logic [31:0] a, logic [31:0] b);
    int sa;
    int sb;
    logic quotient;
    logic signed_op;
    sa = a;
    sb = b;
    quotient = op == execute_pkg::DIV_DIV || op == execute_pkg::DIV_DIVU;
    signed_op = op == execute_pkg::DIV_DIV || op == execute_pkg::DIV_REM;
    if (b == 32'h0) begin
      return quotient ? 32'hffff_ffff : a;
    end
    if (signed_op && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
      return quotient ? a : 32'h0;
    end
    if (signed_op) begin
      return quotient ? sa / sb : sa % sb;
    end
    return quotient ? a / b : a % b;
  endfunction

  function automatic logic [31:0] load_model(logic [2:0] op, logic [1:0] off, logic [31:0] rd);
    logic [31:0] s;
    s = rd >> (8 * off);
    case (op)
      execute_pkg::LSU_LB: return {{24{s[7]}}, s[7:0]};
      execute_pkg::LSU_LBU: return {24'b0, s[7:0]};
      execute_pkg::LSU_LH: return {{16{s[15]}}, s[15:0]};
      execute_pkg::LSU_LHU: return {16'b0, s[15:0]};
      default: return rd;
    endcase
  endfunction

  // Expected outcome of the instruction now completing
  function automatic expect_t reference_result();
    expect_t r;
    r.exc = 1'b1;
    r.addr = waddr;
    r.data = 32'h0;
    r.epc = pc;
    r.tval = instr;
    r.cycle = cycle;
    if (illegal) begin
      r.cause = 4'd2;
    end else if (ebreak) begin
      r.cause = 4'd3;
    end else if (ecall) begin
      r.cause = 4'd11;
    end else if ((load || store) && mem_error) begin
      r.cause = load ? 4'd5 : 4'd7;
      r.tval = address;
    end else begin
      r.exc = 1'b0;
      r.cause = 4'd0;
    end
    if (mult) begin
      r.data = mul_model(mul_op, rdata1, rdata2);
    end else if (division) begin
      r.data = div_model(div_op, rdata1, rdata2);
    end else if (load) begin
      r.data = load_model(lsu_op, address[1:0], mem_rdata);
    end else if (auipc) begin
      r.data = address;
    end else if (lui) begin
      r.data = imm;
    end else if (jal || jalr) begin
      // A compressed jump links to the next halfword
      r.data = (&instr[1:0]) ? pc + 32'd4 : pc + 32'd2;
    end else begin
      r.data = alu_model(alu_op, rdata1, rden2 ? rdata2 : imm);
    end
    r.valid = r.exc || (wren && waddr != 5'd0);
    return r;
  endfunction

  task automatic report_value(string name, logic [31:0] exp, logic [31:0] act);
    $display("Error at %0d ns: %s expected %h, got %h", $time, name, exp, act);
    error_count++;
  endtask

  task automatic report_failure(string what);
    $display("Failure at %0d ns: %s", $time, what);
    error_count++;
  endtask

  task automatic compare_result(expect_t head);
    check_count++;
    if (head.exc && !exception) begin
      report_failure("an expected exception did not appear");
    end else if (head.exc) begin
      if (ecause !== head.cause) report_value("ecause", 32'(head.cause), 32'(ecause));
      if (epc !== head.epc) report_value("epc", head.epc, epc);
      if (etval !== head.tval) report_value("etval", head.tval, etval);
      if (write_enable) report_failure("register write alongside an exception");
    end else if (!write_enable) begin
      report_failure("an expected register write did not appear");
    end else begin
      if (write_addr !== head.addr) report_value("write_addr", 32'(head.addr), 32'(write_addr));
      if (write_data !== head.data) report_value("write_data", head.data, write_data);
      if (exception) report_failure("exception raised by an instruction that should write");
    end
    if (retired !== !head.exc) report_value("retired", 32'(!head.exc), 32'(retired));
  endtask

  // Results show one cycle after the instruction completes
  always @(negedge clock) begin
    if (reset) begin
      if (write_enable && write_addr == 5'd0) begin
        report_failure("register 0 was written");
      end
      if (expected.size() > 0 && expected[0].cycle == cycle - 1) begin
        compare_result(expected.pop_front());
      end else if (write_enable || exception) begin
        report_failure("write-back or exception with no instruction completing");
      end
    end
  end

  always @(posedge clock) begin
    cycle = cycle + 1;
    if (cycle > CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test failed");
      $finish;
    end
  end

  task automatic random_fields();
    {wren, rden2, lui, auipc, jal, jalr, load, store} = 8'h0;
    {mult, division, ecall, ebreak, illegal} = 5'h0;
    pc = random_word() & 32'hffff_fffc;
    instr = random_word();
    address = random_word();
    rdata1 = random_word();
    rdata2 = random_word();
    imm = random_word();
    sdata = random_word();
    waddr = 5'(random_below(32));
    rden2 = random_below(2) == 1;
    alu_op = 4'(random_below(10));
    mul_op = 2'(random_below(4));
    div_op = 2'(random_below(4));
    lsu_op = execute_pkg::LSU_LW;
    byte_enable = 4'hf;
    mem_rdata = random_word();
  endtask

  // Kinds 0 to 4 are LB, LBU, LH, LHU and LW, kind 5 a store
  task automatic prepare_memory(int kind);
    int lane;
    lane = random_below(4);
    if (kind >= 2) lane = lane & 2;
    if (kind >= 4) lane = 0;
    load = kind != 5;
    store = kind == 5;
    wren = kind != 5;
    case (kind)
      0: lsu_op = execute_pkg::LSU_LB;
      1: lsu_op = execute_pkg::LSU_LBU;
      2: lsu_op = execute_pkg::LSU_LH;
      3: lsu_op = execute_pkg::LSU_LHU;
      default: lsu_op = execute_pkg::LSU_LW;
    endcase
    address[1:0] = 2'(lane);
    if (kind < 2) begin
      byte_enable = 4'(4'b0001 << lane);
    end else if (kind < 4) begin
      byte_enable = 4'(4'b0011 << lane);
    end
  endtask

  task automatic run_instruction(int mem_delay);
    int waited;
    logic mem_op;
    expect_t r;
    waited = 0;
    mem_op = load | store;
    issue = 1'b1;
    mem_ready = mem_op && mem_delay == 0;
    @(negedge clock);
    while (stall) begin
      @(posedge clock);
      #10;
      waited++;
      if (mem_op && waited == mem_delay) mem_ready = 1'b1;
      @(negedge clock);
    end
    r = reference_result();
    if (r.valid) expected.push_back(r);
    @(posedge clock);
    #10;
    issue = 1'b0;
    mem_ready = 1'b0;
    mem_error = 1'b0;
  endtask

  // The instruction waits in the stage, then clear drops the stall
  task automatic flush_instruction(int hold_cycles);
    issue = 1'b1;
    repeat (hold_cycles) begin
      @(negedge clock);
      if (stall !== 1'b1) report_value("stall", 32'd1, 32'(stall));
      @(posedge clock);
      #10;
    end
    clear = 1'b1;
    @(negedge clock);
    if (stall !== 1'b0) report_value("stall", 32'd0, 32'(stall));
    @(posedge clock);
    #10;
    clear = 1'b0;
    issue = 1'b0;
  endtask

  task automatic finish_test(int number, string name, int count, int errors_before);
    @(posedge clock);
    #10;
    $display("Test %0d %s: %0d instructions, %0d errors", number, name, count,
             error_count - errors_before);
  endtask

  initial begin
    int errors_before;
    int kind;
    reset = 1'b0;
    issue = 1'b0;
    clear = 1'b0;
    mem_ready = 1'b0;
    mem_error = 1'b0;
    random_fields();
    repeat (5) @(posedge clock);
    #10;
    reset = 1'b1;

    errors_before = error_count;
    for (int n = 0; n < 40; n++) begin
      random_fields();
      wren = 1'b1;
      kind = random_below(6);
      lui = kind == 1;
      auipc = kind == 2;
      jal = kind == 3;
      jalr = kind == 4;
      address = pc + imm;
      run_instruction(0);
    end
    finish_test(1, "ALU, LUI, AUIPC and jumps", 40, errors_before);

    errors_before = error_count;
    for (int n = 0; n < 30; n++) begin
      random_fields();
      wren = 1'b1;
      mult = 1'b1;
      waddr = 5'(1 + random_below(31));
      rdata1 = operand_value();
      rdata2 = operand_value();
      run_instruction(0);
    end
    finish_test(2, "multiply", 30, errors_before);

    errors_before = error_count;
    for (int n = 0; n < 30; n++) begin
      random_fields();
      wren = 1'b1;
      division = 1'b1;
      waddr = 5'(1 + random_below(31));
      rdata1 = operand_value();
      rdata2 = operand_value();
      // Overflow and divide by zero for each variant first
      if (n < 8) begin
        rdata1 = 32'h8000_0000;
        rdata2 = (n < 4) ? 32'hffff_ffff : 32'h0;
        div_op = 2'(n % 4);
      end
      run_instruction(0);
    end
    finish_test(3, "divide", 30, errors_before);

    errors_before = error_count;
    for (int n = 0; n < 40; n++) begin
      random_fields();
      prepare_memory(random_below(6));
      run_instruction(random_below(4));
    end
    finish_test(4, "load and store", 40, errors_before);

    errors_before = error_count;
    for (int n = 0; n < 10; n++) begin
      random_fields();
      wren = 1'b1;
      case (n % 5)
        0: illegal = 1'b1;
        1: ebreak = 1'b1;
        2: ecall = 1'b1;
        3: prepare_memory(4);
        default: prepare_memory(5);
      endcase
      mem_error = n % 5 >= 3;
      run_instruction(random_below(4));
    end
    finish_test(5, "exceptions", 10, errors_before);

    errors_before = error_count;
    random_fields();
    wren = 1'b1;
    mult = 1'b1;
    waddr = 5'd7;
    flush_instruction(1);
    random_fields();
    wren = 1'b1;
    mult = 1'b1;
    waddr = 5'd8;
    run_instruction(0);
    random_fields();
    wren = 1'b1;
    division = 1'b1;
    waddr = 5'd9;
    rdata2 = rdata2 | 32'h1;
    flush_instruction(1);
    random_fields();
    wren = 1'b1;
    division = 1'b1;
    waddr = 5'd10;
    rdata2 = rdata2 | 32'h1;
    run_instruction(0);
    random_fields();
    prepare_memory(4);
    waddr = 5'd11;
    flush_instruction(1);
    random_fields();
    wren = 1'b1;
    waddr = 5'd12;
    run_instruction(0);
    finish_test(6, "clear", 6, errors_before);

    if (expected.size() != 0) begin
      report_failure("results were still expected at the end of the run");
    end
    $display("Totals: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: load_align.sv
`default_nettype none

module load_align (
  input  execute_pkg::word_t        rdata,
  input  execute_pkg::byte_enable_t byte_enable,
  input  execute_pkg::lsu_op_t      lsu_op,
  output execute_pkg::word_t        data
);

  logic [7:0] lane_byte;
  logic [15:0] lane_half;

  always_comb begin
    case (byte_enable)
      4'b0010: lane_byte = rdata[15:8];
      4'b0100: lane_byte = rdata[23:16];
      4'b1000: lane_byte = rdata[31:24];
      default: lane_byte = rdata[7:0];
    endcase
  end

  // Upper half when lanes 2 and 3 are enabled
  assign lane_half = byte_enable[2] ? rdata[31:16] : rdata[15:0];

  always_comb begin
    case (lsu_op)
      execute_pkg::LSU_LB: data = {{24{lane_byte[7]}}, lane_byte};
      execute_pkg::LSU_LBU: data = {24'b0, lane_byte};
      execute_pkg::LSU_LH: data = {{16{lane_half[15]}}, lane_half};
      execute_pkg::LSU_LHU: data = {16'b0, lane_half};
      default: data = rdata;
    endcase
  end

endmodule

`default_nettype wire

// File: multiplier.sv
`default_nettype none

module multiplier #(
  parameter int MUL_STAGES = 2
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 enable,
  input  execute_pkg::mul_op_t op,
  input  execute_pkg::word_t   rdata1,
  input  execute_pkg::word_t   rdata2,
  output logic                 ready,
  output execute_pkg::word_t   result
);

  logic a_signed;
  logic b_signed;
  logic signed [32:0] a_ext;
  logic signed [32:0] b_ext;
  logic signed [65:0] product;
  execute_pkg::word_t product_word;
  execute_pkg::word_t pipe_data [MUL_STAGES];
  logic [MUL_STAGES-1:0] pipe_valid;

  // One extra bit covers every signedness mix
  assign a_signed = (op == execute_pkg::MUL_MULH) || (op == execute_pkg::MUL_MULHSU);
  assign b_signed = op == execute_pkg::MUL_MULH;
  assign a_ext = {a_signed & rdata1[31], rdata1};
  assign b_ext = {b_signed & rdata2[31], rdata2};
  assign product = a_ext * b_ext;

  assign product_word = (op == execute_pkg::MUL_MUL) ? product[31:0] : product[63:32];

  always_ff @(posedge clock) begin
    pipe_data[0] <= product_word;
    for (int i = 1; i < MUL_STAGES; i++) begin
      pipe_data[i] <= pipe_data[i-1];
    end
  end

  // Valid bit shifts alongside the data
  always_ff @(posedge clock) begin
    if (reset == 0) begin
      pipe_valid <= '0;
    end else begin
      pipe_valid[0] <= enable;
      for (int i = 1; i < MUL_STAGES; i++) begin
        pipe_valid[i] <= pipe_valid[i-1];
      end
    end
  end

  assign ready = pipe_valid[MUL_STAGES-1];
  assign result = pipe_data[MUL_STAGES-1];

endmodule

`default_nettype wire

// File: rv_execute.f
execute_pkg.sv
alu.sv
multiplier.sv
divider.sv
load_align.sv
execute_stage.sv
execute_unit.sv
execute_unit_tb.sv
